//--- bench/picc_init_tb.sv
module picc_init_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_VEC        = 32;
    localparam int MAX_BYTES      = 8;
    localparam int CYCLES_PER_VEC = 200;
    localparam int REPLY_WAIT     = 10;
    // double UID, bytes 0x11 to 0x77 with uid[7:0] first
    localparam iso14443a_pkg::uid_t CARD_UID = 80'h0000_0077_6655_4433_2211;

    logic                     clk;
    logic                     rst_n;
    iso14443a_pkg::rx_frame_t rx;
    iso14443a_pkg::rx_bit_t   rx_bits;
    logic                     crc_ok;
    iso14443a_pkg::uid_t      uid;
    logic                     tx_req;
    iso14443a_pkg::tx_out_t   tx;

    // vector table
    string                name_v  [MAX_VEC];
    int                   len_v   [MAX_VEC];
    iso14443a_pkg::byte_t frame_v [MAX_VEC][MAX_BYTES];
    int                   last_v  [MAX_VEC];
    int                   err_v   [MAX_VEC];
    int                   crc_v   [MAX_VEC];
    int                   rlen_v  [MAX_VEC];
    int                   rbits_v [MAX_VEC];
    int                   rcrc_v  [MAX_VEC];
    iso14443a_pkg::byte_t reply_v [MAX_VEC][MAX_BYTES];

    int nvec;
    int errors;
    int cycle_count;
    int cycle_limit;

    picc_init #(.UID_SIZE(iso14443a_pkg::UID_DOUBLE)) uut (
        .clk, .rst_n, .rx, .rx_bits, .crc_ok, .uid, .tx_req, .tx
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ============================================================
    // helpers
    // ============================================================

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(string name, string what, int expected, int actual);
        if (expected != actual) begin
            $display("FAILED %s %s expected %h actual %h", name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic read_vectors();
        int    fd;
        int    code;
        int    v;
        string tok;
        string line;
        fd = $fopen("bench/picc_init_vectors.txt", "r");
        if (fd == 0) begin
            $display("vector file bench/picc_init_vectors.txt could not be opened");
            errors++;
            return;
        end
        while (!$feof(fd) && nvec < MAX_VEC) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) break;
            // comment line, skip the rest of it
            if (tok.substr(0, 0) == "#") begin
                code = $fgets(line, fd);
                continue;
            end
            name_v[nvec] = tok;
            code = $fscanf(fd, "%d", len_v[nvec]);
            for (int i = 0; i < len_v[nvec]; i++) begin
                code = $fscanf(fd, "%h", v);
                frame_v[nvec][i] = v[7:0];
            end
            code = $fscanf(fd, "%d %d %d", last_v[nvec], err_v[nvec], crc_v[nvec]);
            code = $fscanf(fd, "%d %d %d", rlen_v[nvec], rbits_v[nvec], rcrc_v[nvec]);
            for (int i = 0; i < rlen_v[nvec]; i++) begin
                code = $fscanf(fd, "%h", v);
                reply_v[nvec][i] = v[7:0];
            end
            nvec++;
        end
        $fclose(fd);
    endtask

    // soc, then per byte its bit strobes LSB first and the byte strobe, then eoc
    task automatic send_frame(int v);
        int  nbits;
        logic last;
        crc_ok = crc_v[v][0];
        rx.soc = 1'b1;
        next_cycle();
        rx = '0;
        for (int b = 0; b < len_v[v]; b++) begin
            last  = (b == len_v[v] - 1);
            nbits = (last && last_v[v] != 0) ? last_v[v] : 8;
            for (int k = 0; k < nbits; k++) begin
                rx_bits.data_valid = 1'b1;
                rx_bits.data       = frame_v[v][b][k];
                next_cycle();
                rx_bits = '0;
            end
            rx.data_valid = 1'b1;
            rx.data       = frame_v[v][b];
            // a partial byte closes the frame itself
            if (last && last_v[v] != 0) begin
                rx.eoc   = 1'b1;
                rx.error = err_v[v][0];
            end
            next_cycle();
            rx = '0;
        end
        if (last_v[v] == 0) begin
            rx.eoc   = 1'b1;
            rx.error = err_v[v][0];
            next_cycle();
            rx = '0;
        end
    endtask

    task automatic expect_silence(int v);
        for (int n = 0; n < REPLY_WAIT; n++) begin
            if (tx.data_valid) begin
                $display("%s: card replied although no reply was expected", name_v[v]);
                errors++;
                return;
            end
            next_cycle();
        end
    endtask

    task automatic collect_reply(int v);
        int                     n;
        int                     count;
        int                     gap;
        int                     mask;
        iso14443a_pkg::tx_out_t hold;
        // called one cycle after eoc, first transfer is due on the next edge
        n = 0;
        while (!tx.data_valid && n < REPLY_WAIT) begin
            next_cycle();
            n++;
        end
        if (!tx.data_valid) begin
            $display("%s: no reply from the card", name_v[v]);
            errors++;
            return;
        end
        check_value(name_v[v], "latency after eoc", 2, n + 1);
        count = 0;
        while (tx.data_valid && count < MAX_BYTES) begin
            // only the first transfer may be a partial byte
            mask = (count == 0 && rbits_v[v] != 0) ? ((1 << rbits_v[v]) - 1) : 255;
            if (count < rlen_v[v]) begin
                check_value(name_v[v], $sformatf("byte %0d", count),
                            32'(reply_v[v][count]) & mask, 32'(tx.data) & mask);
            end
            check_value(name_v[v], "data_bits", (count == 0) ? rbits_v[v] : 0,
                        32'(tx.data_bits));
            check_value(name_v[v], "append_crc", rcrc_v[v], 32'(tx.append_crc));
            // withhold tx_req, the transfer must stay put
            gap = $urandom_range(3, 0);
            if (count == 0) gap = gap + 2;
            hold = tx;
            for (int g = 0; g < gap; g++) begin
                next_cycle();
                check_value(name_v[v], "held transfer", 32'(hold), 32'(tx));
            end
            tx_req = 1'b1;
            next_cycle();
            tx_req = 1'b0;
            count++;
        end
        check_value(name_v[v], "transfer count", rlen_v[v], count);
    endtask

    // ============================================================
    // main sequence
    // ============================================================

    initial begin
        rst_n       = 1'b0;
        rx          = '0;
        rx_bits     = '0;
        crc_ok      = 1'b0;
        uid         = CARD_UID;
        tx_req      = 1'b0;
        nvec        = 0;
        errors      = 0;
        cycle_limit = CYCLES_PER_VEC * MAX_VEC;
        void'($urandom(62994));
        read_vectors();
        if (nvec == 0) begin
            $display("no vectors were read");
            errors++;
        end
        cycle_limit = nvec * CYCLES_PER_VEC;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        for (int v = 0; v < nvec; v++) begin
            send_frame(v);
            if (rlen_v[v] == 0) begin
                expect_silence(v);
            end else begin
                collect_reply(v);
            end
            repeat (2) next_cycle();
        end
        $display("%0d vectors run, %0d errors", nvec, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog over the whole run, the limit is known after the first edge
    initial begin
        cycle_count = 0;
        @(posedge clk);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, run aborted after %0d cycles", cycle_count);
        $display("Test failed");
        $finish;
    end

endmodule

//--- bench/picc_init_vectors.txt
# name nbytes frame_bytes(hex) last_bits rx_err crc_ok nreply first_bits append_crc reply(hex)
# last_bits 0 means a full final byte, first_bits 0 means a full first transfer
reqa_idle        1 26 7 0 0 2 0 0 44 00
ac_nvb20         2 93 20 0 0 0 5 0 0 88 11 22 33 88
ac_nvb25         3 93 25 08 5 0 0 5 3 0 04 11 22 33 88
ac_nvb40         4 93 40 88 11 0 0 0 3 0 0 22 33 88
ac_nvb32         4 93 32 88 01 2 0 0 4 6 0 04 22 33 88
ac_mismatch      3 93 30 89 0 0 0 0 0 0
reqa_again       1 26 7 0 0 2 0 0 44 00
ac_rx_error      2 93 20 0 1 0 0 0 0
ac_after_error   2 93 20 0 0 0 0 0 0
reqa_after_error 1 26 7 0 0 2 0 0 44 00
select_cl1       7 93 70 88 11 22 33 88 0 0 1 1 0 1 04
ac_cl2           2 95 20 0 0 0 5 0 0 44 55 66 77 00
select_cl2       7 95 70 44 55 66 77 00 0 0 1 1 0 1 20
hlta_active      2 50 00 0 0 1 0 0 0
reqa_halted      1 26 7 0 0 0 0 0
wupa_halted      1 52 7 0 0 2 0 0 44 00
select_bad_crc   7 93 70 88 11 22 33 88 0 0 0 0 0 0
ac_after_bad_crc 2 93 20 0 0 0 0 0 0

//--- common/iso14443a_pkg.sv
package iso14443a_pkg;

    // ==========================================================
    // width types
    // ==========================================================

    typedef logic [7:0]  byte_t;
    // valid bits in a partial byte, 0 stands for a full byte
    typedef logic [2:0]  bit_count_t;
    // room for a triple size UID, smaller sizes leave the top unused
    typedef logic [79:0] uid_t;
    typedef logic [1:0]  level_t;

    typedef enum logic [1:0] {
        UID_SINGLE,
        UID_DOUBLE,
        UID_TRIPLE
    } uid_size_e;

    // ==========================================================
    // frame level structs
    // ==========================================================

    // byte strobes from the frame decoder
    typedef struct packed {
        logic  soc;
        logic  eoc;
        logic  error;
        logic  data_valid;
        byte_t data;
    } rx_frame_t;

    // per bit strobe, runs alongside the byte strobes
    typedef struct packed {
        logic data_valid;
        logic data;
    } rx_bit_t;

    typedef struct packed {
        logic       data_valid;
        byte_t      data;
        bit_count_t data_bits;
        logic       append_crc;
    } tx_out_t;

    // what the current cascade level looks like on the air
    typedef struct packed {
        logic [31:0] uid;
        byte_t       bcc;
        byte_t       sel_code;
        logic        is_final;
    } level_uid_t;

    // decoded command, valid while pkt_received is high
    typedef struct packed {
        logic       pkt_received;
        logic       rx_error;
        logic       is_reqa;
        logic       is_wupa;
        logic       is_hlta;
        logic       is_ac_select;
        logic       is_select;
        logic       for_us;
        logic       crc_ok;
        logic [2:0] nvb_bytes;
        bit_count_t nvb_bits;
    } cmd_flags_t;

    typedef enum logic [1:0] {
        REPLY_NONE,
        REPLY_ATQA,
        REPLY_AC,
        REPLY_SAK
    } reply_e;

    // ==========================================================
    // command codes, see ISO 14443-3 section 6.5
    // ==========================================================

    // short frames, 7 bits
    localparam logic [6:0] REQA = 7'h26;
    localparam logic [6:0] WUPA = 7'h52;
    // first byte in the low half
    localparam logic [15:0] HLTA = 16'h0050;

    localparam byte_t SEL1             = 8'h93;
    localparam byte_t SEL2             = 8'h95;
    localparam byte_t SEL3             = 8'h97;
    localparam byte_t CASCADE_TAG      = 8'h88;
    localparam byte_t SAK_COMPLETE     = 8'h20;
    localparam byte_t SAK_NOT_COMPLETE = 8'h04;

    // SEL + NVB + 4 UID bytes + BCC, CRC is checked upstream
    localparam int RX_BUFF_LEN  = 7;
    // 4 UID bytes + BCC
    localparam int AC_REPLY_LEN = 5;

    // UID size bits of ATQA, also the index of the last cascade level
    function automatic logic [1:0] uid_size_code(uid_size_e size);
        case (size)
            UID_SINGLE: return 2'd0;
            UID_DOUBLE: return 2'd1;
            default:    return 2'd2;
        endcase
    endfunction

endpackage

//--- picc_init.f
common/iso14443a_pkg.sv
src/cascade_uid.sv
src/rx_capture.sv
src/picc_fsm.sv
src/tx_reply.sv
src/picc_init.sv
bench/picc_init_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module picc_init_tb -f picc_init.f -o picc_init_sim
./obj_dir/picc_init_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failed" sim.log || ! grep -q "Test passed" sim.log; then
    echo "simulation FAILED, see sim.log"
    exit 1
fi
echo "simulation passed"

//--- src/cascade_uid.sv
module cascade_uid #(
    parameter iso14443a_pkg::uid_size_e UID_SIZE = iso14443a_pkg::UID_DOUBLE
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  iso14443a_pkg::uid_t       uid,
    input  logic                      level_reset,
    input  logic                      level_advance,
    output iso14443a_pkg::level_uid_t level_info
);

    localparam iso14443a_pkg::level_t LAST_LEVEL = iso14443a_pkg::uid_size_code(UID_SIZE);

    iso14443a_pkg::level_t level_q;
    logic [31:0]           word;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level_q <= '0;
        end else if (level_reset) begin
            level_q <= '0;
        end else if (level_advance) begin
            level_q <= level_q + 2'd1;
        end
    end

    // ISO 14443-3 6.5.4: a non final level is CT + 3 UID bytes,
    // the final level carries the last 4 UID bytes
    always_comb begin
        case (level_q)
            2'd0:    word = (LAST_LEVEL == 2'd0) ? uid[31:0]
                                                 : {uid[23:0], iso14443a_pkg::CASCADE_TAG};
            2'd1:    word = (LAST_LEVEL == 2'd1) ? uid[55:24]
                                                 : {uid[47:24], iso14443a_pkg::CASCADE_TAG};
            default: word = uid[79:48];
        endcase
    end

    assign level_info.uid      = word;
    // check byte over the four bytes of this level
    assign level_info.bcc      = word[31:24] ^ word[23:16] ^ word[15:8] ^ word[7:0];
    assign level_info.sel_code = (level_q == 2'd0) ? iso14443a_pkg::SEL1 :
                                 (level_q == 2'd1) ? iso14443a_pkg::SEL2 :
                                                     iso14443a_pkg::SEL3;
    assign level_info.is_final = (level_q == LAST_LEVEL);

    // the FSM may only advance from a non final level
    a_level_range: assert property (@(posedge clk) disable iff (!rst_n)
        level_q <= LAST_LEVEL);

endmodule

//--- src/picc_fsm.sv
module picc_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  iso14443a_pkg::cmd_flags_t flags,
    input  iso14443a_pkg::level_uid_t level_info,
    output iso14443a_pkg::reply_e     reply,
    output logic                      level_reset,
    output logic                      level_advance
);

    // HALT and the star states are IDLE/READY/ACTIVE plus the star bit
    typedef enum logic [1:0] {
        IDLE,
        READY,
        ACTIVE
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   star_q;
    logic   star_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            star_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            star_q  <= star_d;
        end
    end

    // ==========================================================
    // transitions, ISO 14443-3 section 6.3
    // ==========================================================

    always_comb begin
        state_d       = state_q;
        star_d        = star_q;
        reply         = iso14443a_pkg::REPLY_NONE;
        level_reset   = 1'b0;
        level_advance = 1'b0;

        if (flags.pkt_received) begin
            if (flags.rx_error) begin
                // star bit survives
                state_d = IDLE;
            end else begin
                case (state_q)
                    IDLE: begin
                        // halted card only wakes on WUPA
                        if ((flags.is_reqa && !star_q) || flags.is_wupa) begin
                            state_d     = READY;
                            reply       = iso14443a_pkg::REPLY_ATQA;
                            level_reset = 1'b1;
                        end
                    end
                    READY: begin
                        if (flags.is_ac_select && flags.for_us) begin
                            if (!flags.is_select) begin
                                reply = iso14443a_pkg::REPLY_AC;
                            end else if (!flags.crc_ok) begin
                                state_d = IDLE;
                            end else begin
                                reply = iso14443a_pkg::REPLY_SAK;
                                if (level_info.is_final) begin
                                    state_d = ACTIVE;
                                end else begin
                                    level_advance = 1'b1;
                                end
                            end
                        end else begin
                            state_d = IDLE;
                        end
                    end
                    ACTIVE: begin
                        // no RATS path, everything drops back to IDLE
                        state_d = IDLE;
                        if (flags.is_hlta) begin
                            star_d = 1'b1;
                        end
                    end
                    default: state_d = IDLE;
                endcase
            end
        end
    end

    // one decision per frame, pkt_received is a single cycle pulse
    a_pkt_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        flags.pkt_received |=> !flags.pkt_received);

endmodule

//--- src/picc_init.sv
module picc_init #(
    parameter iso14443a_pkg::uid_size_e UID_SIZE = iso14443a_pkg::UID_DOUBLE
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  iso14443a_pkg::rx_frame_t rx,
    input  iso14443a_pkg::rx_bit_t   rx_bits,
    input  logic                     crc_ok,
    input  iso14443a_pkg::uid_t      uid,
    input  logic                     tx_req,
    output iso14443a_pkg::tx_out_t   tx
);

    iso14443a_pkg::level_uid_t level_info;
    iso14443a_pkg::cmd_flags_t flags;
    iso14443a_pkg::reply_e     reply;
    iso14443a_pkg::byte_t [iso14443a_pkg::AC_REPLY_LEN-1:0] ac_reply;

    logic level_reset;
    logic level_advance;

    // capture -> decide -> reply, cascade_uid feeds the current level to all
    cascade_uid #(.UID_SIZE(UID_SIZE)) u_cascade_uid (
        .clk, .rst_n, .uid, .level_reset, .level_advance, .level_info
    );

    rx_capture u_rx_capture (
        .clk, .rst_n, .rx, .rx_bits, .crc_ok, .level_info, .flags, .ac_reply
    );

    picc_fsm u_picc_fsm (
        .clk, .rst_n, .flags, .level_info, .reply, .level_reset, .level_advance
    );

    tx_reply #(.UID_SIZE(UID_SIZE)) u_tx_reply (
        .clk, .rst_n, .reply, .flags, .ac_reply, .level_info, .tx_req, .tx
    );

endmodule

//--- src/rx_capture.sv
module rx_capture (
    input  logic                      clk,
    input  logic                      rst_n,
    input  iso14443a_pkg::rx_frame_t  rx,
    input  iso14443a_pkg::rx_bit_t    rx_bits,
    input  logic                      crc_ok,
    input  iso14443a_pkg::level_uid_t level_info,
    output iso14443a_pkg::cmd_flags_t flags,
    output iso14443a_pkg::byte_t [iso14443a_pkg::AC_REPLY_LEN-1:0] ac_reply
);

    iso14443a_pkg::byte_t [iso14443a_pkg::RX_BUFF_LEN-1:0] rx_buf;

    logic [2:0] rx_count;
    logic       err_q;
    logic       crc_q;
    logic       pkt_received;
    logic       uid_matching;
    logic       for_us;
    logic       sel_match;
    logic       buf_room;
    logic       ac_load;

    // ==========================================================
    // frame buffering
    // ==========================================================

    assign buf_room  = (rx_count != 3'(iso14443a_pkg::RX_BUFF_LEN));
    assign sel_match = (rx_buf[0] == level_info.sel_code);
    // SEL and NVB in, this level's SEL code
    assign ac_load   = rx.data_valid && buf_room && (rx_count == 3'd1) && sel_match;

    always_ff @(posedge clk) begin
        if (rx.data_valid && buf_room) begin
            rx_buf[rx_count] <= rx.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_count     <= '0;
            err_q        <= 1'b0;
            crc_q        <= 1'b0;
            pkt_received <= 1'b0;
            uid_matching <= 1'b0;
            for_us       <= 1'b0;
        end else begin
            // one cycle after eoc, partial bytes have landed by then
            pkt_received <= rx.eoc;

            if (rx.soc) begin
                rx_count     <= '0;
                err_q        <= 1'b0;
                uid_matching <= 1'b0;
                for_us       <= 1'b0;
            end

            if (rx.eoc) begin
                crc_q <= crc_ok;
            end

            // sticky until the next frame
            if (rx.error) begin
                err_q <= 1'b1;
            end

            if (ac_load) begin
                uid_matching <= 1'b1;
                for_us       <= 1'b1;
            end

            // partial bytes are not counted so count/bits line up with NVB
            if (rx.data_valid && buf_room && !rx.eoc) begin
                rx_count <= rx_count + 3'd1;
                // BCC done, anything further is CRC
                if (rx_count == 3'd6) begin
                    uid_matching <= 1'b0;
                end
            end

            // one wrong prefix bit and the frame is not ours
            if (uid_matching && rx_bits.data_valid && (rx_bits.data != ac_reply[0][0])) begin
                uid_matching <= 1'b0;
                for_us       <= 1'b0;
            end
        end
    end

    // ==========================================================
    // anticollision reply buffer
    // ==========================================================

    // head bit is always the next expected UID bit, what is left over
    // after the frame is exactly what we still have to send
    always_ff @(posedge clk) begin
        if (ac_load) begin
            // LSB first on air, so uid[7:0] lands in byte 0
            ac_reply <= {level_info.bcc, level_info.uid};
        end else if (uid_matching) begin
            // bit strobes of a byte come before its byte strobe
            if (rx.data_valid && !rx.eoc) begin
                ac_reply[3:0] <= ac_reply[4:1];
            end else if (rx_bits.data_valid) begin
                ac_reply[0][6:0] <= ac_reply[0][7:1];
            end
        end
    end

    // ==========================================================
    // command decode
    // ==========================================================

    assign flags.pkt_received = pkt_received;
    assign flags.rx_error     = err_q;
    assign flags.is_reqa      = (rx_buf[0][6:0] == iso14443a_pkg::REQA);
    assign flags.is_wupa      = (rx_buf[0][6:0] == iso14443a_pkg::WUPA);
    assign flags.is_hlta      = (rx_buf[0] == iso14443a_pkg::HLTA[7:0]) &&
                                (rx_buf[1] == iso14443a_pkg::HLTA[15:8]) && crc_q;
    assign flags.is_ac_select = sel_match;
    // NVB 0x70 means all 7 bytes, a full SELECT
    assign flags.is_select    = sel_match && (rx_buf[1] == 8'h70);
    assign flags.for_us       = for_us;
    assign flags.crc_ok       = crc_q;
    assign flags.nvb_bytes    = rx_buf[1][6:4];
    assign flags.nvb_bits     = rx_buf[1][2:0];

endmodule

//--- src/tx_reply.sv
module tx_reply #(
    parameter iso14443a_pkg::uid_size_e UID_SIZE = iso14443a_pkg::UID_DOUBLE
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  iso14443a_pkg::reply_e     reply,
    input  iso14443a_pkg::cmd_flags_t flags,
    input  iso14443a_pkg::byte_t [iso14443a_pkg::AC_REPLY_LEN-1:0] ac_reply,
    input  iso14443a_pkg::level_uid_t level_info,
    input  logic                      tx_req,
    output iso14443a_pkg::tx_out_t    tx
);

    // high byte 0x00, size code in bits 7:6 of the low byte
    localparam logic [15:0] ATQA = {8'h00, iso14443a_pkg::uid_size_code(UID_SIZE), 6'h04};

    iso14443a_pkg::byte_t [iso14443a_pkg::AC_REPLY_LEN-1:0] buf_q;

    iso14443a_pkg::bit_count_t bits_q;
    iso14443a_pkg::byte_t      sak;
    logic                      valid_q;
    logic                      crc_q;
    // transfers left after the current one
    logic [2:0]                count_q;
    logic                      advance;

    assign sak     = level_info.is_final ? iso14443a_pkg::SAK_COMPLETE
                                         : iso14443a_pkg::SAK_NOT_COMPLETE;
    assign advance = tx_req && valid_q && (count_q != 3'd0);

    always_ff @(posedge clk) begin
        case (reply)
            iso14443a_pkg::REPLY_ATQA: buf_q <= {24'd0, ATQA};
            iso14443a_pkg::REPLY_AC:   buf_q <= ac_reply;
            iso14443a_pkg::REPLY_SAK:  buf_q <= {32'd0, sak};
            default: begin
                if (advance) begin
                    buf_q <= {8'h00, buf_q[4:1]};
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            crc_q   <= 1'b0;
            bits_q  <= '0;
            count_q <= '0;
        end else begin
            case (reply)
                iso14443a_pkg::REPLY_ATQA: begin
                    valid_q <= 1'b1;
                    crc_q   <= 1'b0;
                    bits_q  <= '0;
                    count_q <= 3'd1;
                end
                iso14443a_pkg::REPLY_AC: begin
                    valid_q <= 1'b1;
                    crc_q   <= 1'b0;
                    // 8 - nvb bits, 0 wraps to a full byte
                    bits_q  <= 3'd0 - flags.nvb_bits;
                    // 7 - nvb bytes transfers, counted minus one
                    count_q <= 3'd6 - flags.nvb_bytes;
                end
                iso14443a_pkg::REPLY_SAK: begin
                    valid_q <= 1'b1;
                    crc_q   <= 1'b1;
                    bits_q  <= '0;
                    count_q <= 3'd0;
                end
                default: begin
                    if (advance) begin
                        count_q <= count_q - 3'd1;
                        bits_q  <= '0;
                    end else if (tx_req) begin
                        valid_q <= 1'b0;
                    end
                end
            endcase
        end
    end

    assign tx = '{data_valid: valid_q, data: buf_q[0], data_bits: bits_q, append_crc: crc_q};

    // the transfer count wraps for an NVB outside 2 to 6 whole bytes
    a_ac_nvb_range: assert property (@(posedge clk) disable iff (!rst_n)
        (reply == iso14443a_pkg::REPLY_AC) |->
            ((flags.nvb_bytes >= 3'd2) && (flags.nvb_bytes <= 3'd6)));

endmodule
